//--- project.f
rv_pkg.sv
fetch_unit.sv
decoder.sv
alu_exec.sv
reg_file.sv
core_top.sv
core_sva.sv
tb_top.sv

//--- Makefile
TOP := tb_top

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f -o sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f project.f

clean:
	rm -rf obj_dir

//--- tb_top.sv
`timescale 1ns/1ps
module tb_top;

	localparam rv_pkg::xlen_t reset_pc = 32'h80000000;
	localparam int mem_words = 64;
	localparam int reset_cycles = 10;
	localparam int req_timeout = 50;
	localparam int halt_timeout = 2000;
	localparam int opc_imm = 7'b0010011;
	localparam int opc_lui = 7'b0110111;
	localparam int opc_auipc = 7'b0010111;
	localparam int opc_jalr = 7'b1100111;
	localparam rv_pkg::xlen_t ebreak = 32'h00100073;

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	logic arready = 1'b0;
	logic rvalid = 1'b0;
	rv_pkg::xlen_t rdata = '0;
	logic arvalid;
	rv_pkg::xlen_t araddr;
	logic retire_valid;
	rv_pkg::retire_t retire;
	logic finished;
	rv_pkg::xlen_t halt_ret;

	rv_pkg::xlen_t mem [mem_words];
	rv_pkg::xlen_t idx;
	logic random_mode = 1'b0;
	int seed = 14;
	int phase;
	int gap;
	int retire_count;
	int test_errs = 0;
	int passed = 0;
	int failed = 0;

	core_top #(
		.RESET_PC(reset_pc)
	) dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.arready(arready),
		.rvalid(rvalid),
		.rdata(rdata),
		.arvalid(arvalid),
		.araddr(araddr),
		.retire_valid(retire_valid),
		.retire(retire),
		.finished(finished),
		.halt_ret(halt_ret)
	);

	always #4 clk = ~clk;

	function automatic int next_gap();
		if (!random_mode) begin
			return 0;
		end
		return $unsigned($random(seed)) % 4; // 0 to 3 idle cycles.
	endfunction

	// memory model, one request at a time.
	always @(negedge clk) begin
		if (!rst_n) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
			phase <= 0;
			gap <= next_gap();
		end else begin
			case (phase)
				0: if (arvalid) begin
					if (gap == 0) begin
						arready <= 1'b1;
						idx <= (araddr - reset_pc) >> 2;
						phase <= 1;
					end else begin
						gap <= gap - 1;
					end
				end
				1: begin
					arready <= 1'b0; // handshake took place at the last rising edge.
					gap <= next_gap();
					phase <= 2;
				end
				2: if (gap == 0) begin
					rvalid <= 1'b1;
					rdata <= (idx < mem_words) ? mem[idx[5:0]] : '0;
					phase <= 3;
				end else begin
					gap <= gap - 1;
				end
				default: begin
					rvalid <= 1'b0;
					gap <= next_gap();
					phase <= 0;
				end
			endcase
		end
	end

	// each retire is checked against the word the memory served.
	always @(posedge clk) begin
		if (!rst_n) begin
			retire_count <= 0;
		end else if (retire_valid) begin
			retire_count <= retire_count + 1;
			check_retire(rdata, reset_pc + {idx[29:0], 2'b00});
		end
	end

	function automatic rv_pkg::xlen_t enc_r(input int f7, input int rs2, input int rs1,
		input int f3, input int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic rv_pkg::xlen_t enc_i(input int imm, input int rs1, input int f3,
		input int rd, input int opc);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
	endfunction

	function automatic rv_pkg::xlen_t enc_b(input int imm, input int rs2, input int rs1,
		input int f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic rv_pkg::xlen_t enc_j(input int imm, input int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
	endfunction

	function automatic rv_pkg::xlen_t enc_u(input int imm20, input int rd, input int opc);
		return {imm20[19:0], rd[4:0], opc[6:0]};
	endfunction

	task automatic clear_mem();
		for (int i = 0; i < mem_words; i++) begin
			mem[i[5:0]] = {i[24:0], 7'b0000000}; // illegal opcode, retires as a no-op.
		end
	endtask

	task automatic load_arith();
		clear_mem();
		mem[0] = enc_i(100, 0, 0, 1, opc_imm);   // x1 = 100
		mem[1] = enc_i(-7, 0, 0, 2, opc_imm);    // x2 = -7
		mem[2] = enc_r(0, 2, 1, 0, 3);           // x3 = 93
		mem[3] = enc_r(32, 1, 2, 0, 4);          // x4 = -107
		mem[4] = enc_i(4, 3, 1, 5, opc_imm);     // x5 = 0x5d0
		mem[5] = enc_r(32, 1, 4, 5, 6);          // sra by 100 mod 32, x6 = -7
		mem[6] = enc_r(0, 1, 2, 2, 7);           // x7 = 1
		mem[7] = enc_r(0, 6, 5, 4, 8);           // x8 = 0xfffffa29
		mem[8] = enc_u('h12345, 9, opc_lui);
		mem[9] = enc_u(1, 11, opc_auipc);        // x11 = 0x80001024
		mem[10] = enc_r(0, 7, 8, 0, 10);
		mem[11] = enc_r(0, 9, 10, 4, 10);
		mem[12] = enc_r(0, 11, 10, 0, 10);
		mem[13] = ebreak;
	endtask

	// 40 retires: 3 setup, 10 loop passes of 3, call, return, 4 after, ebreak.
	task automatic load_branch();
		clear_mem();
		mem[0] = enc_i(0, 0, 0, 10, opc_imm);
		mem[1] = enc_i(1, 0, 0, 5, opc_imm);
		mem[2] = enc_i(11, 0, 0, 6, opc_imm);
		mem[3] = enc_r(0, 5, 10, 0, 10);         // loop body.
		mem[4] = enc_i(1, 5, 0, 5, opc_imm);
		mem[5] = enc_b(-8, 6, 5, 1);             // bne back to the loop body.
		mem[6] = enc_j(28, 1);                   // call word 13.
		mem[7] = enc_u(0, 8, opc_auipc);
		mem[8] = enc_r(32, 8, 1, 0, 9);          // zero if the link was right.
		mem[9] = enc_r(0, 9, 10, 0, 10);
		mem[10] = enc_j(8, 0);
		mem[11] = enc_i(256, 10, 0, 10, opc_imm); // skipped.
		mem[12] = ebreak;
		mem[13] = enc_i(0, 1, 0, 0, opc_jalr);
	endtask

	task automatic load_x0();
		clear_mem();
		mem[0] = enc_i(5, 0, 0, 0, opc_imm);
		mem[1] = enc_i(7, 0, 0, 10, opc_imm);
		mem[2] = enc_r(0, 0, 0, 0, 10);
		mem[3] = ebreak;
	endtask

	task automatic check_value(input string name, input rv_pkg::xlen_t exp,
		input rv_pkg::xlen_t got);
		assert (got === exp) else begin
			$display("Fail %s expected %08h got %08h", name, exp, got);
			test_errs++;
		end
	endtask

	task automatic check_retire(input rv_pkg::xlen_t word, input rv_pkg::xlen_t addr);
		logic writes;
		// branches carry immediate bits in the rd field.
		writes = (word[6:0] != 7'b1100011) && (word[11:7] != 5'd0);
		check_value("retire.pc", addr, retire.pc);
		check_value("retire.wen", {31'b0, writes}, {31'b0, retire.wen});
		if (writes) begin
			check_value("retire.rd", {27'b0, word[11:7]}, {27'b0, retire.rd});
		end
		if ((word[6:0] == 7'b1101111 || word[6:0] == opc_jalr[6:0]) && writes) begin
			check_value("retire.data", addr + 32'd4, retire.data); // link address.
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond) else begin
			$display("%s", what);
			test_errs++;
		end
	endtask

	task automatic apply_reset();
		rst_n <= 1'b0;
		repeat (reset_cycles) @(negedge clk);
		check_value("arvalid", 32'd0, {31'b0, arvalid});
		check_value("finished", 32'd0, {31'b0, finished});
		rst_n <= 1'b1;
	endtask

	task automatic wait_arvalid();
		int n;
		n = 0;
		while (!arvalid && n < req_timeout) begin
			@(negedge clk);
			n++;
		end
		check_true(arvalid, "the core raised no fetch request after reset");
	endtask

	task automatic wait_finished();
		int n;
		n = 0;
		while (!finished && n < halt_timeout) begin
			@(negedge clk);
			n++;
		end
		check_true(finished, "the core did not halt in time");
	endtask

	task automatic end_test(input string name);
		if (test_errs == 0) begin
			$display("test %s: ok", name);
			passed++;
		end else begin
			$display("test %s: %0d errors", name, test_errs);
			failed++;
		end
		test_errs = 0;
	endtask

	initial begin
		@(negedge clk);
		load_x0();
		apply_reset();
		wait_arvalid();
		check_value("araddr", reset_pc, araddr);
		end_test("reset");

		load_arith();
		apply_reset();
		wait_finished();
		check_value("halt_ret", 32'h6dcbba4e, halt_ret);
		end_test("arith");

		load_branch();
		apply_reset();
		wait_finished();
		check_value("halt_ret", 32'h00000037, halt_ret);
		check_value("retire_count", 32'd40, retire_count);
		end_test("control");

		load_x0();
		apply_reset();
		wait_finished();
		check_value("halt_ret", 32'd0, halt_ret);
		end_test("x0");

		// the core stays parked after ebreak.
		repeat (20) begin
			@(negedge clk);
			check_value("arvalid", 32'd0, {31'b0, arvalid});
			check_value("finished", 32'd1, {31'b0, finished});
		end
		end_test("halt");

		random_mode = 1'b1;
		load_branch();
		apply_reset();
		wait_finished();
		check_value("halt_ret", 32'h00000037, halt_ret);
		check_value("retire_count", 32'd40, retire_count);
		end_test("backpressure");

		$display("passed %0d, failed %0d", passed, failed);
		if (failed == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

//--- core_sva.sv
`timescale 1ns/1ps
module core_sva (
	input logic clk,
	input logic rst_n,
	input logic arvalid,
	input logic arready,
	input rv_pkg::xlen_t araddr,
	input logic rvalid,
	input logic retire_valid,
	input logic finished
);

	logic pending; // address accepted, data not yet back.

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pending <= 1'b0;
		end else if (arvalid && arready) begin
			pending <= 1'b1;
		end else if (rvalid) begin
			pending <= 1'b0;
		end
	end

	addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
		arvalid && !arready |=> arvalid && $stable(araddr))
	else $error("fetch request dropped or moved while stalled");

	single_request: assert property (@(posedge clk) disable iff (!rst_n)
		pending |-> !arvalid)
	else $error("new fetch request while a response is pending");

	// data must answer an accepted request.
	retire_on_data: assert property (@(posedge clk) disable iff (!rst_n)
		retire_valid |-> rvalid && pending)
	else $error("retire without read data for an accepted request");

	halt_parked: assert property (@(posedge clk) disable iff (!rst_n)
		finished |=> finished && !arvalid)
	else $error("core left the halted state");

endmodule

bind core_top core_sva sva_i (
	.clk(clk),
	.rst_n(rst_n),
	.arvalid(arvalid),
	.arready(arready),
	.araddr(araddr),
	.rvalid(rvalid),
	.retire_valid(retire_valid),
	.finished(finished)
);

//--- core_top.sv
`timescale 1ns/1ps
module core_top #(
	parameter rv_pkg::xlen_t RESET_PC = 32'h80000000
) (
	input logic clk,
	input logic rst_n,
	input logic arready,
	input logic rvalid,
	input rv_pkg::xlen_t rdata,
	output logic arvalid,
	output rv_pkg::xlen_t araddr,
	output logic retire_valid,
	output rv_pkg::retire_t retire,
	output logic finished,
	output rv_pkg::xlen_t halt_ret
);

	rv_pkg::xlen_t inst;
	rv_pkg::xlen_t pc;
	rv_pkg::xlen_t next_pc;
	rv_pkg::xlen_t src1;
	rv_pkg::xlen_t src2;
	rv_pkg::xlen_t result;
	rv_pkg::decoded_t dec;
	logic inst_valid;
	logic halt_req;

	fetch_unit #(
		.RESET_PC(RESET_PC)
	) fetch_i (
		.clk(clk),
		.rst_n(rst_n),
		.arready(arready),
		.rvalid(rvalid),
		.rdata(rdata),
		.next_pc(next_pc),
		.halt_req(halt_req),
		.arvalid(arvalid),
		.araddr(araddr),
		.inst(inst),
		.pc(pc),
		.inst_valid(inst_valid)
	);

	decoder decode_i (
		.inst(inst),
		.dec(dec)
	);

	alu_exec exec_i (
		.dec(dec),
		.pc(pc),
		.src1(src1),
		.src2(src2),
		.result(result),
		.next_pc(next_pc)
	);

	reg_file rf_i (
		.clk(clk),
		.rst_n(rst_n),
		.raddr1(dec.rs1),
		.raddr2(dec.rs2),
		.wr(retire),
		.wr_valid(inst_valid),
		.rdata1(src1),
		.rdata2(src2),
		.a0(halt_ret)
	);

	assign halt_req = (dec.op == rv_pkg::op_halt);

	// retires in the rvalid cycle itself.
	assign retire_valid = inst_valid;
	assign retire = '{pc: pc, rd: dec.rd, data: result, wen: dec.rd_wen};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			finished <= 1'b0;
		end else if (inst_valid && halt_req) begin
			finished <= 1'b1; // sticky until reset.
		end
	end

endmodule

//--- reg_file.sv
`timescale 1ns/1ps
module reg_file (
	input logic clk,
	input logic rst_n,
	input rv_pkg::reg_idx_t raddr1,
	input rv_pkg::reg_idx_t raddr2,
	input rv_pkg::retire_t wr,
	input logic wr_valid,
	output rv_pkg::xlen_t rdata1,
	output rv_pkg::xlen_t rdata2,
	output rv_pkg::xlen_t a0
);

	rv_pkg::xlen_t regs [32];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_valid && wr.wen && wr.rd != '0) begin
			regs[wr.rd] <= wr.data;
		end
	end

	// x0 reads as zero.
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

	assign a0 = regs[10]; // x10.

endmodule

//--- alu_exec.sv
`timescale 1ns/1ps
module alu_exec (
	input rv_pkg::decoded_t dec,
	input rv_pkg::xlen_t pc,
	input rv_pkg::xlen_t src1,
	input rv_pkg::xlen_t src2,
	output rv_pkg::xlen_t result,
	output rv_pkg::xlen_t next_pc
);

	rv_pkg::xlen_t op_b;
	rv_pkg::xlen_t alu_out;
	rv_pkg::xlen_t pc_plus4;
	rv_pkg::xlen_t pc_imm;
	rv_pkg::xlen_t jalr_tgt;
	logic [4:0] shamt;
	logic taken;

	assign op_b = (dec.op == rv_pkg::op_alu) ? src2 : dec.imm;
	assign shamt = op_b[4:0];
	assign pc_plus4 = pc + 32'd4;
	assign pc_imm = pc + dec.imm; // branch and jal target, auipc value.
	assign jalr_tgt = (src1 + dec.imm) & ~32'd1;

	always_comb begin
		case (dec.alu_fn)
			rv_pkg::alu_add: alu_out = src1 + op_b;
			rv_pkg::alu_sub: alu_out = src1 - op_b;
			rv_pkg::alu_sll: alu_out = src1 << shamt;
			rv_pkg::alu_slt: alu_out = {31'b0, $signed(src1) < $signed(op_b)};
			rv_pkg::alu_sltu: alu_out = {31'b0, src1 < op_b};
			rv_pkg::alu_xor: alu_out = src1 ^ op_b;
			rv_pkg::alu_srl: alu_out = src1 >> shamt;
			rv_pkg::alu_sra: alu_out = $signed(src1) >>> shamt;
			rv_pkg::alu_or: alu_out = src1 | op_b;
			rv_pkg::alu_and: alu_out = src1 & op_b;
			default: alu_out = '0;
		endcase
	end

	always_comb begin
		case (dec.funct3)
			3'b000: taken = (src1 == src2); // beq.
			3'b001: taken = (src1 != src2);
			3'b100: taken = ($signed(src1) < $signed(src2));
			3'b101: taken = ($signed(src1) >= $signed(src2));
			3'b110: taken = (src1 < src2);
			3'b111: taken = (src1 >= src2); // bgeu.
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		result = alu_out;
		next_pc = pc_plus4;
		case (dec.op)
			rv_pkg::op_lui: result = dec.imm;
			rv_pkg::op_auipc: result = pc_imm;
			rv_pkg::op_jal: begin
				result = pc_plus4; // link.
				next_pc = pc_imm;
			end
			rv_pkg::op_jalr: begin
				result = pc_plus4;
				next_pc = jalr_tgt;
			end
			rv_pkg::op_branch: begin
				if (taken) begin
					next_pc = pc_imm;
				end
			end
			default: ;
		endcase
	end

endmodule

//--- decoder.sv
`timescale 1ns/1ps
module decoder (
	input rv_pkg::xlen_t inst,
	output rv_pkg::decoded_t dec
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic f7_std;
	logic f7_alt;
	logic r_ok;
	logic i_ok;
	rv_pkg::xlen_t imm_i;
	rv_pkg::xlen_t imm_b;
	rv_pkg::xlen_t imm_u;
	rv_pkg::xlen_t imm_j;

	function automatic rv_pkg::alu_fn_e alu_fn_of(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: return alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
			3'b001: return rv_pkg::alu_sll;
			3'b010: return rv_pkg::alu_slt;
			3'b011: return rv_pkg::alu_sltu;
			3'b100: return rv_pkg::alu_xor;
			3'b101: return alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
			3'b110: return rv_pkg::alu_or;
			default: return rv_pkg::alu_and;
		endcase
	endfunction

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	assign f7_std = (funct7 == 7'b0000000);
	assign f7_alt = (funct7 == 7'b0100000);

	// alternate funct7 only for sub and sra.
	assign r_ok = f7_std || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
	// immediate shifts carry funct7 in the upper immediate bits.
	assign i_ok = (funct3 == 3'b001) ? f7_std :
		(funct3 == 3'b101) ? (f7_std || f7_alt) : 1'b1;

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		dec.op = rv_pkg::op_illegal;
		dec.alu_fn = rv_pkg::alu_add;
		dec.funct3 = funct3;
		dec.rd = inst[11:7];
		dec.rs1 = inst[19:15];
		dec.rs2 = inst[24:20];
		dec.imm = imm_i;
		case (opcode)
			rv_pkg::opc_op: if (r_ok) begin
				dec.op = rv_pkg::op_alu;
				dec.alu_fn = alu_fn_of(funct3, funct7[5]);
			end
			rv_pkg::opc_op_imm: if (i_ok) begin
				dec.op = rv_pkg::op_alu_imm;
				dec.alu_fn = alu_fn_of(funct3, funct7[5] && funct3 == 3'b101); // no subi.
			end
			rv_pkg::opc_lui: begin
				dec.op = rv_pkg::op_lui;
				dec.imm = imm_u;
			end
			rv_pkg::opc_auipc: begin
				dec.op = rv_pkg::op_auipc;
				dec.imm = imm_u;
			end
			rv_pkg::opc_branch: if (funct3 != 3'b010 && funct3 != 3'b011) begin
				dec.op = rv_pkg::op_branch;
				dec.imm = imm_b;
			end
			rv_pkg::opc_jal: begin
				dec.op = rv_pkg::op_jal;
				dec.imm = imm_j;
			end
			rv_pkg::opc_jalr: if (funct3 == 3'b000) begin
				dec.op = rv_pkg::op_jalr;
			end
			rv_pkg::opc_system: if (inst == rv_pkg::ebreak_inst) begin
				dec.op = rv_pkg::op_halt;
			end
			default: ;
		endcase
		// only writing classes, and never x0.
		dec.rd_wen = (dec.op inside {rv_pkg::op_alu, rv_pkg::op_alu_imm, rv_pkg::op_lui,
			rv_pkg::op_auipc, rv_pkg::op_jal, rv_pkg::op_jalr}) && (dec.rd != '0);
	end

endmodule

//--- fetch_unit.sv
`timescale 1ns/1ps
module fetch_unit #(
	parameter rv_pkg::xlen_t RESET_PC = 32'h80000000
) (
	input logic clk,
	input logic rst_n,
	input logic arready,
	input logic rvalid,
	input rv_pkg::xlen_t rdata,
	input rv_pkg::xlen_t next_pc,
	input logic halt_req,
	output logic arvalid,
	output rv_pkg::xlen_t araddr,
	output rv_pkg::xlen_t inst,
	output rv_pkg::xlen_t pc,
	output logic inst_valid
);

	typedef enum logic [1:0] {
		st_boot,
		st_req,
		st_wait,
		st_park
	} state_e;

	state_e state;
	rv_pkg::xlen_t pc_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= st_boot;
			pc_q <= RESET_PC;
		end else begin
			case (state)
				st_boot: state <= st_req; // first fetch after reset.
				st_req: begin
					if (arready) begin
						state <= st_wait;
					end
				end
				st_wait: begin
					if (rvalid) begin
						pc_q <= next_pc;
						state <= halt_req ? st_park : st_req;
					end
				end
				default: state <= st_park; // stays here until reset.
			endcase
		end
	end

	assign arvalid = (state == st_req);
	assign araddr = pc_q; // only moves on retire, so stable under back-pressure.

	// rvalid outside a pending request is ignored.
	assign inst_valid = rvalid && (state == st_wait);
	assign inst = rdata;
	assign pc = pc_q;

endmodule

//--- rv_pkg.sv
package rv_pkg;

	typedef logic [31:0] xlen_t;
	typedef logic [4:0] reg_idx_t;

	// rv32i major opcodes.
	localparam logic [6:0] opc_op = 7'b0110011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_lui = 7'b0110111;
	localparam logic [6:0] opc_auipc = 7'b0010111;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_jal = 7'b1101111;
	localparam logic [6:0] opc_jalr = 7'b1100111;
	localparam logic [6:0] opc_system = 7'b1110011;

	localparam xlen_t ebreak_inst = 32'h00100073; // full word, no other system op is kept.

	typedef enum logic [3:0] {
		op_alu,
		op_alu_imm,
		op_lui,
		op_auipc,
		op_branch,
		op_jal,
		op_jalr,
		op_halt,
		op_illegal
	} op_e;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and
	} alu_fn_e;

	typedef struct packed {
		op_e op;
		alu_fn_e alu_fn;
		logic [2:0] funct3; // branch compare select.
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		xlen_t imm;
		logic rd_wen;
	} decoded_t;

	// one retired instruction.
	typedef struct packed {
		xlen_t pc;
		reg_idx_t rd;
		xlen_t data;
		logic wen;
	} retire_t;

endpackage
